//--- hw/calc_params.svh
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

`define CALC_DATA_W 32	// operand and result width

`define CALC_PORTS 4	// request ports on the calculator

`define CALC_SHAMT_W 5	// shift amount bits taken from operand 2

`define CALC_TAG_W 2	// enough bits to number every port

`endif

//--- hw/calc_pkg.sv
package calc_pkg;

	// command codes as seen on reqN_cmd_in
	typedef enum logic [3:0] {
		cmd_nop = 4'd0,	// idle level on the bus, never answered
		cmd_add = 4'd1,	// op1 + op2
		cmd_sub = 4'd2,	// op1 - op2
		cmd_shl = 4'd5,	// op1 << op2[4:0]
		cmd_shr = 4'd6	// op1 >> op2[4:0]
	} cmd_e;

	// response codes as seen on out_respN
	typedef enum logic [1:0] {
		resp_none    = 2'd0,	// nothing to report this cycle
		resp_ok      = 2'd1,	// data is valid
		resp_err     = 2'd2,	// overflow or underflow, data forced to 0
		resp_invalid = 2'd3	// unknown command, data forced to 0
	} resp_e;

endpackage

//--- hw/calc_bus_pkg.sv
`include "calc_params.svh"

package calc_bus_pkg;

	// request from a port to the dispatcher and on to the alu
	typedef struct packed {
		logic [`CALC_TAG_W-1:0]  tag;	// which port asked
		logic [3:0]              cmd;	// raw code so bad values reach the alu
		logic [`CALC_DATA_W-1:0] op1;	// sent with the command
		logic [`CALC_DATA_W-1:0] op2;	// sent one cycle later
	} calc_req_t;

	// result broadcast from the alu to every port
	typedef struct packed {
		logic                    valid;	// one cycle per finished request
		logic [`CALC_TAG_W-1:0]  tag;	// copied from the request
		calc_pkg::resp_e         resp;
		logic [`CALC_DATA_W-1:0] data;	// zero unless resp is ok
	} calc_res_t;

endpackage

//--- hw/calc_port.sv
`timescale 1ns/100ps
`include "calc_params.svh"

module calc_port #(
	parameter int PORT_ID = 0	// tag stamped on every request of this port
) (
	input  logic                    c_clk,
	input  logic                    reset,
	input  logic [3:0]              cmd,
	input  logic [`CALC_DATA_W-1:0] data,
	input  logic                    grant,
	input  calc_bus_pkg::calc_res_t result,
	output logic                    req_pending,
	output calc_bus_pkg::calc_req_t req,
	output calc_pkg::resp_e         resp,
	output logic [`CALC_DATA_W-1:0] resp_data
);

	typedef enum logic [1:0] {
		st_idle,	// waiting for a nonzero command
		st_op2,	// operand 2 is on the data bus now
		st_pend,	// request held until the dispatcher grants it
		st_busy	// in the pipeline, waiting for our tag
	} state_t;

	localparam logic [`CALC_TAG_W-1:0] my_tag = `CALC_TAG_W'(PORT_ID);

	state_t                  state;
	logic [3:0]              cmd_q;	// raw command as captured
	logic [`CALC_DATA_W-1:0] op1_q;
	logic [`CALC_DATA_W-1:0] op2_q;
	logic                    start;	// new command accepted this cycle
	logic                    hit;	// broadcast result belongs to us

	assign start = (state == st_idle) && (cmd != 4'd0);	// command 0 is just idle
	assign hit = result.valid && (result.tag == my_tag);

	assign req_pending = (state == st_pend);
	assign req = '{tag: my_tag, cmd: cmd_q, op1: op1_q, op2: op2_q};

	always_ff @(posedge c_clk) begin
		if (reset) begin
			state <= st_idle;
			resp <= calc_pkg::resp_none;
		end else begin
			resp <= hit ? result.resp : calc_pkg::resp_none;	// single cycle pulse
			case (state)
				st_idle: if (start) state <= st_op2;
				st_op2:  state <= st_pend;	// op2 is taken on this edge
				st_pend: if (grant) state <= st_busy;
				st_busy: if (hit) state <= st_idle;	// free again once answered
				default: state <= st_idle;
			endcase
		end
	end

	// captured operands and returned data
	always_ff @(posedge c_clk) begin
		if (start) begin
			cmd_q <= cmd;
			op1_q <= data;
		end
		if (state == st_op2) begin
			op2_q <= data;	// same bus, next cycle
		end
		resp_data <= hit ? result.data : '0;
	end

	// one request outstanding, so a result for us never comes twice in a row
	a_resp_pulse: assert property (@(posedge c_clk) disable iff (reset)
		resp != calc_pkg::resp_none |=> resp == calc_pkg::resp_none);

	// the dispatcher must only pick ports that are asking
	a_grant_pending: assert property (@(posedge c_clk) disable iff (reset)
		grant |-> state == st_pend);

endmodule

//--- hw/calc_dispatch.sv
`timescale 1ns/100ps
`include "calc_params.svh"

module calc_dispatch (
	input  logic                    c_clk,
	input  logic                    reset,
	input  logic [`CALC_PORTS-1:0]  pending,
	input  calc_bus_pkg::calc_req_t reqs [`CALC_PORTS],
	output logic [`CALC_PORTS-1:0]  grant,
	output calc_bus_pkg::calc_req_t issue,
	output logic                    issue_valid
);

	logic [`CALC_TAG_W-1:0] rr_ptr;	// first port to look at this cycle
	logic [`CALC_TAG_W-1:0] idx;	// port under test in the search
	logic [`CALC_TAG_W-1:0] pick;	// winner of the search
	logic                   found;

	// search upward from rr_ptr with wrap and take the first pending port
	always_comb begin
		grant = '0;
		found = 1'b0;
		pick = rr_ptr;
		idx = rr_ptr;
		for (int i = 0; i < `CALC_PORTS; i++) begin
			idx = rr_ptr + `CALC_TAG_W'(i);	// wraps since ports fill the tag range
			if (!found && pending[idx]) begin
				found = 1'b1;
				pick = idx;
			end
		end
		if (found) begin
			grant[pick] = 1'b1;	// combinational so the port sees it this cycle
		end
	end

	always_ff @(posedge c_clk) begin
		if (reset) begin
			rr_ptr <= '0;
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= found;
			if (found) begin
				rr_ptr <= pick + 1'b1;	// the winner goes to the back of the line
			end
		end
	end

	always_ff @(posedge c_clk) begin
		if (found) begin
			issue <= reqs[pick];	// held until the next grant
		end
	end

	// the issued request names the port that won the grant
	a_issue_tag: assert property (@(posedge c_clk) disable iff (reset)
		found |=> issue.tag == $past(pick));

	// ports filter command 0 before it can ever get here
	a_issue_not_nop: assert property (@(posedge c_clk) disable iff (reset)
		issue_valid |-> issue.cmd != calc_pkg::cmd_nop);

endmodule

//--- hw/calc_alu.sv
`timescale 1ns/100ps
`include "calc_params.svh"

module calc_alu (
	input  logic                    c_clk,
	input  logic                    reset,
	input  calc_bus_pkg::calc_req_t issue,
	input  logic                    issue_valid,
	output calc_bus_pkg::calc_res_t result
);

	calc_pkg::cmd_e            dec_op;	// decoded from the raw code
	logic [`CALC_SHAMT_W-1:0]  shamt;
	logic [`CALC_DATA_W:0]     wide;	// top bit is carry or borrow

	calc_pkg::cmd_e            s1_op;
	logic [`CALC_DATA_W:0]     s1_wide;
	logic [`CALC_TAG_W-1:0]    s1_tag;
	logic                      s1_valid;

	assign shamt = issue.op2[`CALC_SHAMT_W-1:0];	// upper bits of op2 ignored

	// stage 1 decode where any unknown code collapses to nop
	always_comb begin
		case (issue.cmd)
			calc_pkg::cmd_add: dec_op = calc_pkg::cmd_add;
			calc_pkg::cmd_sub: dec_op = calc_pkg::cmd_sub;
			calc_pkg::cmd_shl: dec_op = calc_pkg::cmd_shl;
			calc_pkg::cmd_shr: dec_op = calc_pkg::cmd_shr;
			default:           dec_op = calc_pkg::cmd_nop;
		endcase
	end

	// stage 1 compute
	always_comb begin
		case (dec_op)
			calc_pkg::cmd_add: wide = {1'b0, issue.op1} + {1'b0, issue.op2};
			calc_pkg::cmd_sub: wide = {1'b0, issue.op1} - {1'b0, issue.op2};	// msb is borrow
			calc_pkg::cmd_shl: wide = {1'b0, issue.op1 << shamt};
			calc_pkg::cmd_shr: wide = {1'b0, issue.op1 >> shamt};
			default:           wide = '0;
		endcase
	end

	always_ff @(posedge c_clk) begin
		s1_op <= dec_op;
		s1_wide <= wide;
		s1_tag <= issue.tag;
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= issue_valid;
		end
	end

	// stage 2 classify
	always_ff @(posedge c_clk) begin
		result.tag <= s1_tag;	// tag follows the data
		case (s1_op)
			calc_pkg::cmd_add, calc_pkg::cmd_sub: begin
				result.resp <= s1_wide[`CALC_DATA_W] ? calc_pkg::resp_err : calc_pkg::resp_ok;
				result.data <= s1_wide[`CALC_DATA_W] ? '0 : s1_wide[`CALC_DATA_W-1:0];
			end
			calc_pkg::cmd_shl, calc_pkg::cmd_shr: begin
				result.resp <= calc_pkg::resp_ok;	// shifts cannot fail
				result.data <= s1_wide[`CALC_DATA_W-1:0];
			end
			default: begin
				result.resp <= calc_pkg::resp_invalid;	// nop here means a bad code
				result.data <= '0;
			end
		endcase
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= s1_valid;
		end
	end

	// an add reported as ok never wraps below its first operand
	a_add_no_wrap: assert property (@(posedge c_clk) disable iff (reset)
		result.valid && result.resp == calc_pkg::resp_ok
		&& $past(issue.cmd, 2) == calc_pkg::cmd_add
		|-> result.data >= $past(issue.op1, 2));

endmodule

//--- hw/calc_top.sv
`timescale 1ns/100ps
`include "calc_params.svh"

module calc_top (
	input  logic                    c_clk,
	input  logic                    reset,
	input  logic [3:0]              req1_cmd_in,
	input  logic [3:0]              req2_cmd_in,
	input  logic [3:0]              req3_cmd_in,
	input  logic [3:0]              req4_cmd_in,
	input  logic [`CALC_DATA_W-1:0] req1_data_in,
	input  logic [`CALC_DATA_W-1:0] req2_data_in,
	input  logic [`CALC_DATA_W-1:0] req3_data_in,
	input  logic [`CALC_DATA_W-1:0] req4_data_in,
	output logic [1:0]              out_resp1,
	output logic [1:0]              out_resp2,
	output logic [1:0]              out_resp3,
	output logic [1:0]              out_resp4,
	output logic [`CALC_DATA_W-1:0] out_data1,
	output logic [`CALC_DATA_W-1:0] out_data2,
	output logic [`CALC_DATA_W-1:0] out_data3,
	output logic [`CALC_DATA_W-1:0] out_data4
);

	logic [`CALC_PORTS-1:0][3:0]              cmd_in;	// index 0 is port 1
	logic [`CALC_PORTS-1:0][`CALC_DATA_W-1:0] data_in;
	logic [`CALC_PORTS-1:0][1:0]              resp_out;
	logic [`CALC_PORTS-1:0][`CALC_DATA_W-1:0] data_out;
	logic [`CALC_PORTS-1:0]                   pending;
	logic [`CALC_PORTS-1:0]                   grant;
	calc_bus_pkg::calc_req_t                  reqs [`CALC_PORTS];
	calc_bus_pkg::calc_req_t                  issue;
	logic                                     issue_valid;
	calc_bus_pkg::calc_res_t                  result;	// seen by every port

	assign cmd_in = {req4_cmd_in, req3_cmd_in, req2_cmd_in, req1_cmd_in};
	assign data_in = {req4_data_in, req3_data_in, req2_data_in, req1_data_in};
	assign {out_resp4, out_resp3, out_resp2, out_resp1} = resp_out;
	assign {out_data4, out_data3, out_data2, out_data1} = data_out;

	for (genvar p = 0; p < `CALC_PORTS; p++) begin : g_port
		calc_port #(
			.PORT_ID(p)
		) u_port (
			.c_clk      (c_clk),
			.reset      (reset),
			.cmd        (cmd_in[p]),
			.data       (data_in[p]),
			.grant      (grant[p]),
			.result     (result),
			.req_pending(pending[p]),
			.req        (reqs[p]),
			.resp       (resp_out[p]),
			.resp_data  (data_out[p])
		);
	end

	calc_dispatch u_dispatch (
		.c_clk      (c_clk),
		.reset      (reset),
		.pending    (pending),
		.reqs       (reqs),
		.grant      (grant),
		.issue      (issue),
		.issue_valid(issue_valid)
	);

	calc_alu u_alu (
		.c_clk      (c_clk),
		.reset      (reset),
		.issue      (issue),
		.issue_valid(issue_valid),
		.result     (result)
	);

endmodule

//--- tests/calc_tb_clock.sv
`timescale 1ns/100ps

module calc_tb_clock (
	output logic c_clk,
	output logic reset
);

	initial begin
		c_clk = 1'b0;
		forever #2 c_clk = ~c_clk;	// 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge c_clk);	// held for three rising edges
		reset <= 1'b0;
	end

endmodule

//--- tests/calc_tb.sv
`timescale 1ns/100ps
`include "calc_params.svh"

module calc_tb;

	typedef struct packed {
		logic [1:0]              resp;
		logic [`CALC_DATA_W-1:0] data;
	} answer_t;

	typedef struct packed {
		logic [1:0]              port;	// 0 drives req1
		logic [3:0]              cmd;
		logic [`CALC_DATA_W-1:0] op1;
		logic [`CALC_DATA_W-1:0] op2;
		answer_t                 exp;	// expected response and data
	} vec_t;

	localparam int n_vecs = 13;
	localparam int timeout = 20;	// cycles allowed per wait

	logic c_clk;
	logic reset;
	logic [`CALC_PORTS-1:0][3:0]              cmd_drv;
	logic [`CALC_PORTS-1:0][`CALC_DATA_W-1:0] data_drv;
	logic [`CALC_PORTS-1:0][1:0]              resp_obs;
	logic [`CALC_PORTS-1:0][`CALC_DATA_W-1:0] data_obs;
	vec_t                                     vecs [n_vecs];
	logic [31:0]                              lcg_state;
	int                                       n_pass;
	int                                       n_fail;

	calc_tb_clock u_clock (.c_clk(c_clk), .reset(reset));

	calc_top UUT (
		.c_clk       (c_clk),
		.reset       (reset),
		.req1_cmd_in (cmd_drv[0]),
		.req2_cmd_in (cmd_drv[1]),
		.req3_cmd_in (cmd_drv[2]),
		.req4_cmd_in (cmd_drv[3]),
		.req1_data_in(data_drv[0]),
		.req2_data_in(data_drv[1]),
		.req3_data_in(data_drv[2]),
		.req4_data_in(data_drv[3]),
		.out_resp1   (resp_obs[0]),
		.out_resp2   (resp_obs[1]),
		.out_resp3   (resp_obs[2]),
		.out_resp4   (resp_obs[3]),
		.out_data1   (data_obs[0]),
		.out_data2   (data_obs[1]),
		.out_data3   (data_obs[2]),
		.out_data4   (data_obs[3])
	);

	function automatic logic [31:0] lcg_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;	// numerical recipes constants
		return lcg_state;
	endfunction

	// expected answer straight from the command rules
	function automatic answer_t ref_calc(input logic [3:0] cmd, input logic [31:0] a,
			input logic [31:0] b);
		answer_t ans;
		ans.resp = calc_pkg::resp_ok;
		ans.data = '0;
		case (cmd)
			4'd1: if (a > ~b) ans.resp = calc_pkg::resp_err;	// a + b above all ones
				else ans.data = a + b;
			4'd2: if (a < b) ans.resp = calc_pkg::resp_err;	// would go negative
				else ans.data = a - b;
			4'd5: ans.data = a << b[4:0];
			4'd6: ans.data = a >> b[4:0];
			default: ans.resp = calc_pkg::resp_invalid;
		endcase
		return ans;
	endfunction

	task automatic put_op1(input int p, input logic [3:0] cmd, input logic [31:0] op1);
		cmd_drv[p] = cmd;
		data_drv[p] = op1;
	endtask

	task automatic put_op2(input int p, input logic [31:0] op2);
		cmd_drv[p] = 4'd0;	// back to idle so the port does not restart
		data_drv[p] = op2;
	endtask

	// sampled on falling edges, half a cycle away from any output change
	task automatic wait_resp(input int p, output logic got, output answer_t ans);
		got = 1'b0;
		ans = '0;
		for (int n = 0; n < timeout && !got; n++) begin
			@(negedge c_clk);
			if (resp_obs[p] != 2'd0) begin
				got = 1'b1;
				ans = {resp_obs[p], data_obs[p]};
			end
		end
	endtask

	task automatic check(input string name, input int p, input answer_t got, input answer_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s port %0d gave resp %0d data %h, expected resp %0d data %h",
				$time, name, p + 1, got.resp, got.data, exp.resp, exp.data);
			n_fail++;
		end else begin
			$display("%s port %0d: resp %0d data %h ok", name, p + 1, got.resp, got.data);
			n_pass++;
		end
	endtask

	task automatic run_one(input string name, input int p, input logic [3:0] cmd,
			input logic [31:0] op1, input logic [31:0] op2, input answer_t exp);
		logic    got;
		answer_t ans;
		@(negedge c_clk);
		put_op1(p, cmd, op1);	// sampled at edge k
		@(negedge c_clk);
		put_op2(p, op2);	// sampled at edge k+1
		wait_resp(p, got, ans);
		if (!got) begin
			$display("%s: no response from port %0d", name, p + 1);
			n_fail++;
		end else begin
			check(name, p, ans, exp);
		end
	endtask

	// all ports at once, each must answer once with its own result
	task automatic run_concurrent();
		logic [3:0]  c [`CALC_PORTS];
		logic [31:0] a [`CALC_PORTS];
		logic [31:0] b [`CALC_PORTS];
		logic [31:0] r;
		answer_t     ans [`CALC_PORTS];
		logic        seen [`CALC_PORTS];
		int          n_seen;
		for (int p = 0; p < `CALC_PORTS; p++) begin
			r = lcg_rand();
			c[p] = (r[3:0] == 4'd0) ? 4'd1 : r[3:0];	// command 0 would never answer
			a[p] = lcg_rand();
			b[p] = lcg_rand();
			seen[p] = 1'b0;
		end
		n_seen = 0;
		@(negedge c_clk);
		for (int p = 0; p < `CALC_PORTS; p++) put_op1(p, c[p], a[p]);
		@(negedge c_clk);
		for (int p = 0; p < `CALC_PORTS; p++) put_op2(p, b[p]);
		for (int n = 0; n < timeout && n_seen < `CALC_PORTS; n++) begin
			@(negedge c_clk);
			for (int p = 0; p < `CALC_PORTS; p++) begin
				if (resp_obs[p] != 2'd0 && seen[p]) begin
					$display("port %0d answered a single command twice", p + 1);
					n_fail++;
				end else if (resp_obs[p] != 2'd0) begin
					seen[p] = 1'b1;
					ans[p] = {resp_obs[p], data_obs[p]};
					n_seen++;
				end
			end
		end
		for (int p = 0; p < `CALC_PORTS; p++) begin
			if (!seen[p]) begin
				$display("concurrent: no response from port %0d", p + 1);
				n_fail++;
			end else begin
				check("concurrent", p, ans[p], ref_calc(c[p], a[p], b[p]));
			end
		end
	endtask

	initial begin
		logic        got;
		answer_t     ans;
		logic [3:0]  ops [4];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		logic        idle_ok;
		cmd_drv = '0;
		data_drv = '0;
		lcg_state = 32'hd259_f183;
		n_pass = 0;
		n_fail = 0;
		ops = '{4'd1, 4'd2, 4'd5, 4'd6};

		// port, cmd, op1, op2, expected response and data
		vecs[0]  = '{2'd0, 4'd1, 32'd100, 32'd23, '{calc_pkg::resp_ok, 32'd123}};
		vecs[1]  = '{2'd1, 4'd2, 32'd1000, 32'd1, '{calc_pkg::resp_ok, 32'd999}};
		vecs[2]  = '{2'd2, 4'd5, 32'd1, 32'd4, '{calc_pkg::resp_ok, 32'd16}};
		vecs[3]  = '{2'd3, 4'd6, 32'h8000_0000, 32'd31, '{calc_pkg::resp_ok, 32'd1}};
		vecs[4]  = '{2'd0, 4'd1, 32'hffff_ffff, 32'd1, '{calc_pkg::resp_err, 32'd0}};	// carry
		vecs[5]  = '{2'd1, 4'd2, 32'd5, 32'd6, '{calc_pkg::resp_err, 32'd0}};	// borrow
		vecs[6]  = '{2'd2, 4'd1, 32'hffff_0000, 32'h0000_ffff, '{calc_pkg::resp_ok, 32'hffff_ffff}};
		vecs[7]  = '{2'd3, 4'd2, 32'h1234_5678, 32'h1234_5678, '{calc_pkg::resp_ok, 32'd0}};
		vecs[8]  = '{2'd0, 4'd5, 32'hdead_beef, 32'd0, '{calc_pkg::resp_ok, 32'hdead_beef}};
		vecs[9]  = '{2'd1, 4'd5, 32'd1, 32'd31, '{calc_pkg::resp_ok, 32'h8000_0000}};
		vecs[10] = '{2'd2, 4'd5, 32'd3, 32'd32, '{calc_pkg::resp_ok, 32'd3}};	// 32 acts as 0
		vecs[11] = '{2'd3, 4'd6, 32'hf000_0000, 32'd36, '{calc_pkg::resp_ok, 32'h0f00_0000}};
		vecs[12] = '{2'd0, 4'd6, 32'h80, 32'hffff_ffe3, '{calc_pkg::resp_ok, 32'h10}};

		for (int n = 0; n < timeout && reset !== 1'b0; n++) @(negedge c_clk);
		if (reset !== 1'b0) begin
			$display("reset was never released");
			n_fail++;
		end

		idle_ok = 1'b1;
		for (int n = 0; n < 8; n++) begin
			@(negedge c_clk);
			if (resp_obs !== '0) idle_ok = 1'b0;	// nothing asked, nothing answered
		end
		if (!idle_ok) begin
			$display("[ERROR] %0t ns: response seen while all ports idle", $time);
			n_fail++;
		end else begin
			$display("idle after reset: ok");
			n_pass++;
		end

		for (int p = 0; p < `CALC_PORTS; p++) begin
			for (int k = 0; k < 4; k++) begin
				a = lcg_rand();
				b = lcg_rand();
				if (ops[k] == 4'd1) begin
					a = a >> 1;	// keeps the sum in range
					b = b >> 1;
				end
				if (ops[k] == 4'd2 && a < b) begin
					t = a;
					a = b;
					b = t;
				end
				run_one("basic", p, ops[k], a, b, ref_calc(ops[k], a, b));
			end
		end

		for (int i = 0; i < n_vecs; i++) begin
			run_one("table", int'(vecs[i].port), vecs[i].cmd, vecs[i].op1, vecs[i].op2,
				vecs[i].exp);
		end

		for (int c = 3; c < 16; c++) begin
			if (c != 5 && c != 6) begin
				run_one("invalid", c % 4, 4'(c), lcg_rand(), lcg_rand(),
					'{calc_pkg::resp_invalid, 32'd0});
			end
		end

		@(negedge c_clk);
		put_op1(1, 4'd0, 32'd7);	// command 0 is the idle level
		@(negedge c_clk);
		put_op2(1, 32'd9);
		wait_resp(1, got, ans);
		if (got) begin
			$display("[ERROR] %0t ns: port 2 answered command 0 with resp %0d", $time, ans.resp);
			n_fail++;
		end else begin
			$display("nop port 2: no response ok");
			n_pass++;
		end

		for (int r = 0; r < 4; r++) run_concurrent();

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- calc.f
+incdir+hw
hw/calc_pkg.sv
hw/calc_bus_pkg.sv
hw/calc_port.sv
hw/calc_dispatch.sv
hw/calc_alu.sv
hw/calc_top.sv
tests/calc_tb_clock.sv
tests/calc_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = calc_tb
FILELIST  = calc.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
